/* sources.f */
cdr_pack.sv
mm_phase_detector.sv
mm_cdr_loop_filter.sv
cdr_state_sampler.sv
mm_cdr_top.sv
tb_mm_cdr_top.sv

/* Bender.yml */
package:
  name: mm_cdr

sources:
  - cdr_pack.sv
  - mm_phase_detector.sv
  - mm_cdr_loop_filter.sv
  - cdr_state_sampler.sv
  - mm_cdr_top.sv
  - target: test
    files:
      - tb_mm_cdr_top.sv

/* tb_mm_cdr_top.sv */
module tb_mm_cdr_top;

    localparam int shift      = 8;
    localparam int est_w      = cdr_pack::n_adc + 2 + shift;
    localparam int n_reset    = 10;
    localparam int n_track    = 400;
    localparam int n_clamp    = 200;
    localparam int n_ext      = 100;
    localparam int n_release  = 50;
    localparam int n_off      = 100;
    localparam int n_snap     = 150;
    localparam int max_cycles = n_reset + n_track + n_clamp + n_ext + n_release + n_off
                              + n_snap + 50;

    typedef logic signed [est_w-1:0] est_t;
    typedef enum logic [1:0] {M_SAMPLE, M_WAIT, M_READY} snap_state_t;

    logic                           clk;
    logic                           ext_rstb;
    cdr_pack::adc_code_t            codes [cdr_pack::n_ti-1:0];
    logic                           ramp_clock;
    logic [3:0]                     kp;
    logic [3:0]                     ki;
    logic [3:0]                     kr;
    logic                           en_ramp;
    logic                           en_freq;
    logic                           en_clamp;
    logic                           en_ext;
    logic                           sample_req;
    logic [cdr_pack::n_adc+shift:0] clamp_amt;
    cdr_pack::pi_ctl_t              ext_pi;
    cdr_pack::pi_ctl_t              pi_ctl;
    cdr_pack::pi_ctl_t              prev_pi;
    logic                           freq_cross;
    est_t                           phase_snap;
    est_t                           freq_snap;
    est_t                           ramp_snap;

    // reference loop state
    cdr_pack::adc_code_t m_last;
    cdr_pack::pd_err_t   m_pd_err;
    cdr_pack::pd_err_t   m_err;
    logic                m_rc_ff;
    logic                m_rc_sync;
    est_t                m_pls;
    est_t                m_neg;
    est_t                m_freq;
    est_t                m_prev_upd;
    est_t                m_cmin;
    est_t                m_cmax;
    est_t                m_phase;
    logic                m_cross;
    snap_state_t         m_state;
    est_t                m_phase_snap;
    est_t                m_freq_snap;
    est_t                m_ramp_snap;

    integer seed;
    int     errors;
    int     cycles;
    int     phase_id;
    string  test_name;

    mm_cdr_top #(
        .prop_width      (4),
        .intg_width      (4),
        .ramp_width      (4),
        .phase_est_shift (shift)
    ) mm_cdr_top_i (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .codes_i          (codes),
        .ramp_clock_i     (ramp_clock),
        .kp_i             (kp),
        .ki_i             (ki),
        .kr_i             (kr),
        .en_ramp_est_i    (en_ramp),
        .en_freq_est_i    (en_freq),
        .en_clamp_i       (en_clamp),
        .clamp_amt_i      (clamp_amt),
        .en_ext_pi_ctl_i  (en_ext),
        .ext_pi_ctl_i     (ext_pi),
        .sample_state_i   (sample_req),
        .pi_ctl_o         (pi_ctl),
        .freq_lvl_cross_o (freq_cross),
        .phase_snap_o     (phase_snap),
        .freq_snap_o      (freq_snap),
        .ramp_snap_o      (ramp_snap)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic int lane_sign(input int v);
        return (v >= 0) ? 1 : -1;  // zero counts as positive
    endfunction

    // one rising edge of the loop with inputs as the DUT sampled them
    task automatic model_step();
        int   sum;
        int   prev;
        int   k;
        est_t e;
        est_t t_kp;
        est_t t_ki;
        est_t t_kr;
        est_t pls_upd;
        est_t neg_upd;
        est_t upd;
        est_t step;
        est_t ramp_out;
        e        = m_err;
        t_kp     = e <<< kp;
        t_ki     = e <<< ki;
        t_kr     = e <<< kr;
        pls_upd  = ramp_clock ? m_pls + t_kr : m_pls;
        neg_upd  = ramp_clock ? m_neg : m_neg + t_kr;
        upd      = m_rc_sync ? t_ki + m_pls : t_ki - m_neg;
        step     = t_kp + m_freq;
        ramp_out = ramp_clock ? pls_upd : neg_upd;
        if (en_clamp && step > m_cmax) begin
            step = m_cmax;
        end else if (en_clamp && step < m_cmin) begin
            step = m_cmin;
        end
        // sampler sees the values just before the edge
        case (m_state)
            M_SAMPLE: begin
                m_phase_snap = m_phase >>> shift;
                m_freq_snap  = upd;
                m_ramp_snap  = ramp_out;
                m_state      = M_WAIT;
            end
            M_WAIT:  m_state = sample_req ? M_WAIT : M_READY;
            default: m_state = sample_req ? M_SAMPLE : M_READY;
        endcase
        m_cross    = (upd > m_prev_upd);
        m_prev_upd = upd;
        if (en_freq) begin
            m_freq = m_freq + upd;
        end
        m_pls     = en_ramp ? pls_upd : est_t'(0);
        m_neg     = en_ramp ? neg_upd : est_t'(0);
        m_rc_sync = m_rc_ff;
        m_rc_ff   = ramp_clock;
        m_cmax    = est_t'(clamp_amt);
        m_cmin    = -m_cmax;
        m_phase   = en_ext ? (est_t'(ext_pi) << shift) : m_phase + step;
        m_err     = -m_pd_err;
        sum       = 0;
        for (k = 0; k < cdr_pack::n_ti; k++) begin
            prev = (k == 0) ? m_last : codes[k-1];
            sum  = sum + codes[k] * lane_sign(prev) - prev * lane_sign(codes[k]);
        end
        m_pd_err = sum >>> cdr_pack::log2_ti;  // floor of the lane mean
        m_last   = codes[cdr_pack::n_ti-1];
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus and checks
    ////////////////////////////////////////////////////////////

    task automatic drive_inputs(input int cyc);
        for (int k = 0; k < cdr_pack::n_ti; k++) begin
            codes[k] = (phase_id == 0) ? '0 : cdr_pack::adc_code_t'($random(seed));
        end
        if ((($random(seed) & 3) == 0) && phase_id != 0) begin
            ramp_clock = ~ramp_clock;
        end
        if (cyc % 16 == 0 && phase_id != 0) begin
            kp = (phase_id == 2) ? 8 + ($random(seed) & 7) : ($random(seed) & 7);
            ki = (phase_id == 2) ? 8 + ($random(seed) & 7) : ($random(seed) & 7);
            kr = (phase_id == 2) ? 8 + ($random(seed) & 7) : ($random(seed) & 7);
        end
        if (phase_id == 2 && cyc == 0) begin
            clamp_amt = 64 + ($random(seed) & 511);  // a few integer steps at most
        end
        en_ramp    = (phase_id != 0 && phase_id != 5);
        en_freq    = en_ramp;
        en_clamp   = (phase_id == 2);
        en_ext     = (phase_id == 3);
        ext_pi     = en_ext ? cdr_pack::pi_ctl_t'($random(seed)) : ext_pi;
        sample_req = (phase_id == 6) && (($random(seed) & 3) == 0);
    endtask

    task automatic compare_value(input string sig, input logic signed [31:0] exp_v,
                                 input logic signed [31:0] act_v);
        assert (exp_v == act_v) else begin
            errors++;
            $display("mismatch %s %s expected %0d actual %0d", test_name, sig, exp_v, act_v);
        end
    endtask

    task automatic verify_outputs(input int cyc);
        logic signed [8:0] jump;
        int                limit;
        if (en_ext) begin
            compare_value("pi_ctl_o", ext_pi, pi_ctl);  // override passes straight through
        end else begin
            compare_value("pi_ctl_o", m_phase[shift +: cdr_pack::n_pi], pi_ctl);
        end
        compare_value("freq_lvl_cross_o", m_cross, freq_cross);
        compare_value("phase_snap_o", m_phase_snap, phase_snap);
        compare_value("freq_snap_o", m_freq_snap, freq_snap);
        compare_value("ramp_snap_o", m_ramp_snap, ramp_snap);
        if (phase_id == 0) begin
            compare_value("pi_ctl_o", 0, pi_ctl);
            compare_value("freq_lvl_cross_o", 0, freq_cross);
            compare_value("phase_snap_o", 0, phase_snap);
            compare_value("freq_snap_o", 0, freq_snap);
            compare_value("ramp_snap_o", 0, ramp_snap);
        end
        // new clamp limits take two edges to reach the step
        if (phase_id == 2 && cyc >= 3) begin
            jump  = pi_ctl - prev_pi;
            limit = (clamp_amt >> shift) + 1;
            assert (jump <= limit && -jump <= limit) else begin
                errors++;
                $display("%s: pi_ctl_o moved by %0d, beyond the clamp limit of %0d",
                         test_name, jump, limit);
            end
        end
        prev_pi = pi_ctl;
    endtask

    task automatic run_phase(input int id, input string name, input int len);
        phase_id  = id;
        test_name = name;
        for (int cyc = 0; cyc < len; cyc++) begin
            @(posedge clk);
            model_step();
            #1;
            drive_inputs(cyc);
            #1;
            verify_outputs(cyc);
        end
    endtask

    initial begin
        seed       = 32'h7e0f;
        errors     = 0;
        phase_id   = 0;
        test_name  = "reset";
        ext_rstb   = 1'b0;
        ramp_clock = 1'b0;
        {kp, ki, kr}                       = '0;
        {en_ramp, en_freq, en_clamp}       = '0;
        {en_ext, sample_req}               = '0;
        clamp_amt  = '0;
        ext_pi     = '0;
        prev_pi    = '0;
        for (int k = 0; k < cdr_pack::n_ti; k++) begin
            codes[k] = '0;
        end
        {m_last, m_pd_err, m_err, m_rc_ff, m_rc_sync, m_cross} = '0;
        {m_pls, m_neg, m_freq, m_prev_upd, m_cmin, m_cmax, m_phase} = '0;
        {m_phase_snap, m_freq_snap, m_ramp_snap} = '0;
        m_state = M_WAIT;
        repeat (4) @(posedge clk);
        #1 ext_rstb = 1'b1;
        run_phase(0, "reset", n_reset);
        run_phase(1, "track", n_track);
        run_phase(2, "clamp", n_clamp);
        run_phase(3, "override", n_ext);
        run_phase(4, "release", n_release);
        run_phase(5, "disabled", n_off);
        run_phase(6, "snapshot", n_snap);
        $display("errors: %0d after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not end within %0d cycles", max_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* mm_cdr_top.sv */
module mm_cdr_top #(
    parameter int prop_width      = 4,
    parameter int intg_width      = 4,
    parameter int ramp_width      = 4,
    parameter int phase_est_shift = 8
) (
    input  logic                                              clk,
    input  logic                                              ext_rstb,
    input  cdr_pack::adc_code_t                               codes_i [cdr_pack::n_ti-1:0],
    input  logic                                              ramp_clock_i,
    input  logic [prop_width-1:0]                             kp_i,
    input  logic [intg_width-1:0]                             ki_i,
    input  logic [ramp_width-1:0]                             kr_i,
    input  logic                                              en_ramp_est_i,
    input  logic                                              en_freq_est_i,
    input  logic                                              en_clamp_i,
    input  logic [cdr_pack::n_adc+phase_est_shift:0]          clamp_amt_i,
    input  logic                                              en_ext_pi_ctl_i,
    input  cdr_pack::pi_ctl_t                                 ext_pi_ctl_i,
    input  logic                                              sample_state_i,
    output cdr_pack::pi_ctl_t                                 pi_ctl_o,
    output logic                                              freq_lvl_cross_o,
    output logic signed [cdr_pack::n_adc+phase_est_shift+1:0] phase_snap_o,
    output logic signed [cdr_pack::n_adc+phase_est_shift+1:0] freq_snap_o,
    output logic signed [cdr_pack::n_adc+phase_est_shift+1:0] ramp_snap_o
);

    cdr_pack::pd_err_t pd_err;

    // live loop state toward the sampler
    logic signed [cdr_pack::n_adc+phase_est_shift+1:0] phase_est_out;
    logic signed [cdr_pack::n_adc+phase_est_shift+1:0] freq_update;
    logic signed [cdr_pack::n_adc+phase_est_shift+1:0] ramp_update;

    mm_phase_detector mm_phase_detector_i (
        .clk      (clk),
        .ext_rstb (ext_rstb),
        .codes_i  (codes_i),
        .pd_err_o (pd_err)
    );

    mm_cdr_loop_filter #(
        .prop_width      (prop_width),
        .intg_width      (intg_width),
        .ramp_width      (ramp_width),
        .phase_est_shift (phase_est_shift)
    ) mm_cdr_loop_filter_i (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .pd_err_i         (pd_err),
        .ramp_clock_i     (ramp_clock_i),
        .kp_i             (kp_i),
        .ki_i             (ki_i),
        .kr_i             (kr_i),
        .en_ramp_est_i    (en_ramp_est_i),
        .en_freq_est_i    (en_freq_est_i),
        .en_clamp_i       (en_clamp_i),
        .clamp_amt_i      (clamp_amt_i),
        .en_ext_pi_ctl_i  (en_ext_pi_ctl_i),
        .ext_pi_ctl_i     (ext_pi_ctl_i),
        .pi_ctl_o         (pi_ctl_o),
        .freq_lvl_cross_o (freq_lvl_cross_o),
        .phase_est_o      (phase_est_out),
        .freq_update_o    (freq_update),
        .ramp_update_o    (ramp_update)
    );

    cdr_state_sampler #(
        .phase_est_shift (phase_est_shift)
    ) cdr_state_sampler_i (
        .clk            (clk),
        .ext_rstb       (ext_rstb),
        .sample_state_i (sample_state_i),
        .phase_est_i    (phase_est_out),
        .freq_update_i  (freq_update),
        .ramp_update_i  (ramp_update),
        .phase_snap_o   (phase_snap_o),
        .freq_snap_o    (freq_snap_o),
        .ramp_snap_o    (ramp_snap_o)
    );

endmodule

/* cdr_state_sampler.sv */
module cdr_state_sampler #(
    parameter int phase_est_shift = 8
) (
    input  logic                                              clk,
    input  logic                                              ext_rstb,
    input  logic                                              sample_state_i, // request level
    input  logic signed [cdr_pack::n_adc+phase_est_shift+1:0] phase_est_i,
    input  logic signed [cdr_pack::n_adc+phase_est_shift+1:0] freq_update_i,
    input  logic signed [cdr_pack::n_adc+phase_est_shift+1:0] ramp_update_i,
    output logic signed [cdr_pack::n_adc+phase_est_shift+1:0] phase_snap_o,
    output logic signed [cdr_pack::n_adc+phase_est_shift+1:0] freq_snap_o,
    output logic signed [cdr_pack::n_adc+phase_est_shift+1:0] ramp_snap_o
);

    localparam int est_w = cdr_pack::n_adc + 2 + phase_est_shift;

    typedef logic signed [est_w-1:0] est_t;

    typedef enum logic [1:0] {
        SAMPLE,
        WAIT,
        READY
    } sampler_state_t;

    sampler_state_t state_q;

    // captured copies, held between requests
    est_t phase_snap_q;
    est_t freq_snap_q;
    est_t ramp_snap_q;

    // arm on a low request, capture one cycle after the next high
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            state_q      <= WAIT;
            phase_snap_q <= '0;
            freq_snap_q  <= '0;
            ramp_snap_q  <= '0;
        end else begin
            case (state_q)
                SAMPLE: begin
                    phase_snap_q <= phase_est_i;
                    freq_snap_q  <= freq_update_i;
                    ramp_snap_q  <= ramp_update_i;
                    state_q      <= WAIT;
                end
                WAIT: begin
                    state_q <= sample_state_i ? WAIT : READY;  // wait for request to drop
                end
                READY: begin
                    state_q <= sample_state_i ? SAMPLE : READY;
                end
                default: begin
                    state_q <= WAIT;
                end
            endcase
        end
    end

    assign phase_snap_o = phase_snap_q;
    assign freq_snap_o  = freq_snap_q;
    assign ramp_snap_o  = ramp_snap_q;

endmodule

/* mm_cdr_loop_filter.sv */
module mm_cdr_loop_filter #(
    parameter int prop_width      = 4,
    parameter int intg_width      = 4,
    parameter int ramp_width      = 4,
    parameter int phase_est_shift = 8
) (
    input  logic                                            clk,
    input  logic                                            ext_rstb,
    input  cdr_pack::pd_err_t                               pd_err_i,
    input  logic                                            ramp_clock_i,
    input  logic [prop_width-1:0]                           kp_i,    // proportional shift
    input  logic [intg_width-1:0]                           ki_i,    // integral shift
    input  logic [ramp_width-1:0]                           kr_i,    // ramp shift
    input  logic                                            en_ramp_est_i,
    input  logic                                            en_freq_est_i,
    input  logic                                            en_clamp_i,
    input  logic [cdr_pack::n_adc+phase_est_shift:0]        clamp_amt_i,
    input  logic                                            en_ext_pi_ctl_i,
    input  cdr_pack::pi_ctl_t                               ext_pi_ctl_i,
    output cdr_pack::pi_ctl_t                               pi_ctl_o,
    output logic                                            freq_lvl_cross_o,
    output logic signed [cdr_pack::n_adc+phase_est_shift+1:0] phase_est_o,
    output logic signed [cdr_pack::n_adc+phase_est_shift+1:0] freq_update_o,
    output logic signed [cdr_pack::n_adc+phase_est_shift+1:0] ramp_update_o
);

    // estimates carry phase_est_shift fraction bits over the error range
    localparam int est_w = cdr_pack::n_adc + 2 + phase_est_shift;

    typedef logic signed [est_w-1:0] est_t;

    cdr_pack::pd_err_t err_q;          // sign-corrected error e

    // scaled error terms
    est_t err_ext;
    est_t err_kp;
    est_t err_ki;
    est_t err_kr;

    // ramp clock synchronizer
    logic ramp_clock_ff;
    logic ramp_clock_sync;

    // ramp estimate, one accumulator per ramp clock phase
    est_t ramp_pls_q;
    est_t ramp_pls_upd;
    est_t ramp_neg_q;
    est_t ramp_neg_upd;

    // frequency path
    est_t freq_est_q;
    est_t freq_upd;
    est_t prev_freq_upd_q;

    // phase path
    est_t clamp_min_q;
    est_t clamp_max_q;
    est_t phase_step;
    est_t phase_step_clamped;
    est_t phase_est_q;
    est_t ext_phase;

    ////////////////////////////////////////////////////////////
    // loop arithmetic
    ////////////////////////////////////////////////////////////

    always_comb begin
        err_ext = est_t'(err_q);        // sign extend before scaling
        err_kp  = err_ext <<< kp_i;
        err_ki  = err_ext <<< ki_i;
        err_kr  = err_ext <<< kr_i;

        // only the accumulator of the current ramp phase moves
        ramp_pls_upd = ramp_pls_q + (ramp_clock_i ? err_kr : est_t'(0));
        ramp_neg_upd = ramp_neg_q + (ramp_clock_i ? est_t'(0) : err_kr);

        // the synchronized ramp clock picks the drift term
        freq_upd = err_ki + (ramp_clock_sync ? ramp_pls_q : -ramp_neg_q);

        phase_step = err_kp + freq_est_q;

        // optional step limit
        if (en_clamp_i && (phase_step < clamp_min_q)) begin
            phase_step_clamped = clamp_min_q;
        end else if (en_clamp_i && (phase_step > clamp_max_q)) begin
            phase_step_clamped = clamp_max_q;
        end else begin
            phase_step_clamped = phase_step;
        end

        // override word lands on the integer part of the estimate
        ext_phase = est_t'(ext_pi_ctl_i) << phase_est_shift;
    end

    ////////////////////////////////////////////////////////////
    // state registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            err_q           <= '0;
            ramp_clock_ff   <= 1'b0;
            ramp_clock_sync <= 1'b0;
            ramp_pls_q      <= '0;
            ramp_neg_q      <= '0;
            freq_est_q      <= '0;
            prev_freq_upd_q <= '0;
            clamp_min_q     <= '0;
            clamp_max_q     <= '0;
            phase_est_q     <= '0;
        end else begin
            err_q           <= -pd_err_i;           // detector sign is opposite to the loop
            ramp_clock_ff   <= ramp_clock_i;
            ramp_clock_sync <= ramp_clock_ff;

            // ramp accumulators held at zero while disabled
            ramp_pls_q <= en_ramp_est_i ? ramp_pls_upd : est_t'(0);
            ramp_neg_q <= en_ramp_est_i ? ramp_neg_upd : est_t'(0);

            if (en_freq_est_i) begin
                freq_est_q <= freq_est_q + freq_upd;
            end
            prev_freq_upd_q <= freq_upd;

            clamp_max_q <= est_t'(clamp_amt_i);
            clamp_min_q <= -est_t'(clamp_amt_i);

            if (en_ext_pi_ctl_i) begin
                phase_est_q <= ext_phase;
            end else begin
                phase_est_q <= phase_est_q + phase_step_clamped;
            end
        end
    end

    // rising frequency update
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            freq_lvl_cross_o <= 1'b0;
        end else begin
            freq_lvl_cross_o <= (freq_upd > prev_freq_upd_q);
        end
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////

    assign pi_ctl_o = en_ext_pi_ctl_i ? ext_pi_ctl_i
                                      : phase_est_q[phase_est_shift +: cdr_pack::n_pi];

    assign phase_est_o   = phase_est_q >>> phase_est_shift; // integer part, sign kept
    assign freq_update_o = freq_upd;
    assign ramp_update_o = ramp_clock_i ? ramp_pls_upd : ramp_neg_upd;

endmodule

/* mm_phase_detector.sv */
module mm_phase_detector (
    input  logic                clk,
    input  logic                ext_rstb,
    input  cdr_pack::adc_code_t codes_i [cdr_pack::n_ti-1:0], // one code per lane
    output cdr_pack::pd_err_t   pd_err_o                      // averaged timing error
);

    // a lane term spans twice the code range, the sum grows by log2 of the lanes
    localparam int term_w = cdr_pack::n_adc + 2;
    localparam int sum_w  = term_w + cdr_pack::log2_ti;

    typedef logic signed [term_w-1:0] term_t;
    typedef logic signed [sum_w-1:0]  sum_t;

    cdr_pack::adc_code_t last_code_q;                      // last lane of previous cycle
    cdr_pack::adc_code_t prev_code [cdr_pack::n_ti-1:0];   // neighbour of each lane
    term_t               lane_term [cdr_pack::n_ti-1:0];
    sum_t                term_sum;

    ////////////////////////////////////////////////////////////
    // neighbour selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        prev_code[0] = last_code_q;  // lane 0 looks back across the cycle boundary
        for (int k = 1; k < cdr_pack::n_ti; k++) begin
            prev_code[k] = codes_i[k-1];
        end
    end

    ////////////////////////////////////////////////////////////
    // mueller-muller terms
    ////////////////////////////////////////////////////////////

    // code_k * sign(prev) - prev * sign(code_k), sign of zero counts as +1
    always_comb begin
        for (int k = 0; k < cdr_pack::n_ti; k++) begin
            lane_term[k] = (prev_code[k][cdr_pack::n_adc-1] ? -term_t'(codes_i[k])
                                                            :  term_t'(codes_i[k]))
                         - (codes_i[k][cdr_pack::n_adc-1]   ? -term_t'(prev_code[k])
                                                            :  term_t'(prev_code[k]));
        end
    end

    always_comb begin
        term_sum = '0;
        for (int k = 0; k < cdr_pack::n_ti; k++) begin
            term_sum = term_sum + sum_t'(lane_term[k]);
        end
    end

    ////////////////////////////////////////////////////////////
    // average and register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            last_code_q <= '0;
            pd_err_o    <= '0;
        end else begin
            last_code_q <= codes_i[cdr_pack::n_ti-1];
            // arithmetic shift keeps the sign of the mean
            pd_err_o    <= cdr_pack::pd_err_t'(term_sum >>> cdr_pack::log2_ti);
        end
    end

endmodule

/* cdr_pack.sv */
package cdr_pack;

    ////////////////////////////////////////////////////////////
    // data-path sizes
    ////////////////////////////////////////////////////////////

    // interleaved lanes delivered per clock, power of two
    localparam int n_ti = 4;

    // lane average shift, log2 of n_ti
    localparam int log2_ti = 2;

    // adc code width
    localparam int n_adc = 8;

    // phase interpolator control width
    localparam int n_pi = 9;

    ////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////

    // one signed lane code from the adc
    typedef logic signed [n_adc-1:0] adc_code_t;

    // averaged mueller-muller timing error, two guard bits over the code
    typedef logic signed [n_adc+1:0] pd_err_t;

    // phase interpolator control word
    typedef logic [n_pi-1:0] pi_ctl_t;

endpackage
